// ==== rtl/lms_pkg.sv ====
// LMS front end shared definitions
package lms_pkg;

   // Pin and sample widths
   localparam int LMS_DATA_W   = 12;
   localparam int ADC_SAMPLE_W = 14;

   typedef logic [LMS_DATA_W-1:0]   dac_word_t;    // One LMS pin word
   typedef logic [ADC_SAMPLE_W-1:0] adc_sample_t;  // Left justified capture

   typedef struct packed {
      adc_sample_t i;
      adc_sample_t q;
   } rx_iq_t;

   typedef struct packed {
      dac_word_t i;
      dac_word_t q;
   } tx_iq_t;

   typedef struct packed {
      rx_iq_t ch1;
      rx_iq_t ch2;
   } rx_iq_pair_t;

   typedef struct packed {
      tx_iq_t ch1;
      tx_iq_t ch2;
   } tx_iq_pair_t;

   // REG_CTRL layout, bit 3 down to bit 0
   typedef struct packed {
      logic lms1_rst_n;
      logic lms2_rst_n;
      logic rx_en;
      logic tx_en;
   } ctrl_t;

   // Register byte offsets
   localparam logic [7:0] REG_CTRL    = 8'h00;
   localparam logic [7:0] REG_SPI_SEL = 8'h04;
   localparam logic [7:0] REG_DIVSW   = 8'h08;
   localparam logic [7:0] REG_LED     = 8'h0C;
   localparam logic [7:0] REG_STATUS  = 8'h10;

   // AXI response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== rtl/lms_rx_capture.sv ====
// LMS ADC receive capture
`timescale 1ns/1ns

module lms_rx_capture
   import lms_pkg::*;
(
   input  logic        lms_clk,
   input  logic        rst_n_i,
   input  ctrl_t       ctrl_i,
   input  logic        rx1_iqsel_i,
   input  dac_word_t   rx1_d_i,
   input  logic        rx2_iqsel_i,
   input  dac_word_t   rx2_d_i,
   output rx_iq_pair_t rx_iq_o,
   output logic        rx1_valid_o,
   output logic        rx2_valid_o
);

   localparam int PAD_W = ADC_SAMPLE_W - LMS_DATA_W;

   logic      [1:0] pin_iqsel;
   dac_word_t       pin_d [2];

   logic      [1:0] s1_iqsel;   // Registered pin words
   dac_word_t       s1_d [2];

   logic      [1:0] pend_vld;   // I word waiting for its Q
   dac_word_t       pend_i [2];
   logic      [1:0] pair_vld;
   dac_word_t       pair_q [2];

   logic      [1:0] out_vld;
   rx_iq_t          out_iq [2];

   // Index 0 is channel 1
   assign pin_iqsel = {rx2_iqsel_i, rx1_iqsel_i};
   assign pin_d[0]  = rx1_d_i;
   assign pin_d[1]  = rx2_d_i;

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         s1_iqsel <= '0;
         pend_vld <= '0;
         pair_vld <= '0;
         out_vld  <= '0;
      end
      else
      begin
         s1_iqsel <= pin_iqsel;
         // Pairing state is held clear while capture is off
         pend_vld <= {2{ctrl_i.rx_en}} & s1_iqsel;
         pair_vld <= {2{ctrl_i.rx_en}} & ~s1_iqsel & pend_vld;
         out_vld  <= {2{ctrl_i.rx_en}} & pair_vld;
      end
   end

   always_ff @(posedge lms_clk)
   begin
      for (int ch = 0; ch < 2; ch++)
      begin
         s1_d[ch] <= pin_d[ch];
         if (s1_iqsel[ch])
            pend_i[ch] <= s1_d[ch];   // A repeated I word replaces the older one
         else if (pend_vld[ch])
            pair_q[ch] <= s1_d[ch];
         // Left justify into the sample width
         if (pair_vld[ch])
         begin
            out_iq[ch].i <= {pend_i[ch], {PAD_W{1'b0}}};
            out_iq[ch].q <= {pair_q[ch], {PAD_W{1'b0}}};
         end
      end
   end

   assign rx_iq_o.ch1 = out_iq[0];
   assign rx_iq_o.ch2 = out_iq[1];
   assign rx1_valid_o = out_vld[0];
   assign rx2_valid_o = out_vld[1];

   // Pairs in flight are dropped once capture is switched off
   a_rx_off: assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      !ctrl_i.rx_en |=> !(rx1_valid_o || rx2_valid_o));

endmodule

// ==== rtl/lms_tx_interleave.sv ====
// LMS DAC transmit interleave
`timescale 1ns/1ns

module lms_tx_interleave
   import lms_pkg::*;
#(
   parameter int UFLOW_CNT_W = 16
)
(
   input  logic                   lms_clk,
   input  logic                   rst_n_i,
   input  ctrl_t                  ctrl_i,
   input  tx_iq_pair_t            tx_iq_i,
   input  logic                   tx_valid_i,
   output logic                   tx_ready_o,
   output logic                   tx1_en_o,
   output logic                   tx1_iqsel_o,
   output dac_word_t              tx1_d_o,
   output logic                   tx2_en_o,
   output logic                   tx2_iqsel_o,
   output dac_word_t              tx2_d_o,
   output logic [UFLOW_CNT_W-1:0] tx_uflow_cnt_o
);

   logic      q_slot;   // Pins carry the Q slot now
   logic      accept;
   dac_word_t hold_q1;  // Q parts for the slot after acceptance
   dac_word_t hold_q2;

   // Ready only ahead of an I slot
   assign tx_ready_o = ctrl_i.tx_en & q_slot;
   assign accept     = tx_ready_o & tx_valid_i;

   assign tx1_en_o    = ctrl_i.tx_en;
   assign tx2_en_o    = ctrl_i.tx_en;
   assign tx1_iqsel_o = q_slot;
   assign tx2_iqsel_o = q_slot;

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         q_slot         <= 1'b1;
         tx1_d_o        <= '0;
         tx2_d_o        <= '0;
         tx_uflow_cnt_o <= '0;
      end
      else if (!ctrl_i.tx_en)
      begin
         q_slot  <= 1'b1;   // Park on the Q slot
         tx1_d_o <= '0;
         tx2_d_o <= '0;
      end
      else
      begin
         q_slot <= ~q_slot;
         if (q_slot)
         begin
            tx1_d_o <= accept ? tx_iq_i.ch1.i : '0;
            tx2_d_o <= accept ? tx_iq_i.ch2.i : '0;
            if (!accept && tx_uflow_cnt_o != '1)
               tx_uflow_cnt_o <= tx_uflow_cnt_o + 1'b1;   // Saturating
         end
         else
         begin
            tx1_d_o <= hold_q1;
            tx2_d_o <= hold_q2;
         end
      end
   end

   // Underflow leaves zeros for the Q slot too
   always_ff @(posedge lms_clk)
   begin
      if (q_slot)
      begin
         hold_q1 <= accept ? tx_iq_i.ch1.q : '0;
         hold_q2 <= accept ? tx_iq_i.ch2.q : '0;
      end
   end

   // An accepted sample shows up next as an I slot
   a_ready_en: assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      tx_ready_o |-> ctrl_i.tx_en ##1 !tx1_iqsel_o);

   a_iqsel_alt: assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      ctrl_i.tx_en |=> tx1_iqsel_o != $past(tx1_iqsel_o));

endmodule

// ==== rtl/lms_ctrl.sv ====
// LMS control and status registers
`timescale 1ns/1ns

module lms_ctrl
   import lms_pkg::*;
#(
   parameter int AXI_ADDR_W  = 8,
   parameter int UFLOW_CNT_W = 16
)
(
   input  logic                   lms_clk,
   input  logic                   rst_n_i,
   // AXI4-Lite slave
   input  logic [AXI_ADDR_W-1:0]  s_axi_awaddr_i,
   input  logic                   s_axi_awvalid_i,
   output logic                   s_axi_awready_o,
   input  logic [31:0]            s_axi_wdata_i,
   input  logic                   s_axi_wvalid_i,
   output logic                   s_axi_wready_o,
   output logic [1:0]             s_axi_bresp_o,
   output logic                   s_axi_bvalid_o,
   input  logic                   s_axi_bready_i,
   input  logic [AXI_ADDR_W-1:0]  s_axi_araddr_i,
   input  logic                   s_axi_arvalid_i,
   output logic                   s_axi_arready_o,
   output logic [31:0]            s_axi_rdata_o,
   output logic [1:0]             s_axi_rresp_o,
   output logic                   s_axi_rvalid_o,
   input  logic                   s_axi_rready_i,
   // Datapath
   output ctrl_t                  ctrl_o,
   input  logic [UFLOW_CNT_W-1:0] tx_uflow_cnt_i,
   // LMS resets, diversity switches, LEDs
   output logic                   lms1_rst_n_o,
   output logic                   lms2_rst_n_o,
   output logic                   divsw1_p_o,
   output logic                   divsw1_n_o,
   output logic                   divsw2_p_o,
   output logic                   divsw2_n_o,
   output logic [6:0]             leds_n_o,
   // SPI
   input  logic                   spi_sclk_i,
   input  logic                   spi_mosi_i,
   output logic                   spi_miso_o,
   output logic                   sen1_o,
   output logic                   sclk1_o,
   output logic                   mosi1_o,
   input  logic                   miso1_i,
   output logic                   sen2_o,
   output logic                   sclk2_o,
   output logic                   mosi2_o,
   input  logic                   miso2_i,
   output logic                   sen_dac_o,
   output logic                   sclk_dac_o,
   output logic                   mosi_dac_o
);

   ctrl_t      ctrl_q;
   logic [2:0] spi_sel_q;   // LMS1, LMS2, DAC
   logic [1:0] divsw_q;     // Switch 1, switch 2
   logic [6:0] led_q;

   // Address and data taken together, one response outstanding
   assign s_axi_awready_o = s_axi_awvalid_i & s_axi_wvalid_i & ~s_axi_bvalid_o;
   assign s_axi_wready_o  = s_axi_awready_o;
   assign s_axi_arready_o = s_axi_arvalid_i & ~s_axi_rvalid_o;

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         ctrl_q         <= '0;
         spi_sel_q      <= '0;
         divsw_q        <= '0;
         led_q          <= '0;
         s_axi_bvalid_o <= 1'b0;
         s_axi_bresp_o  <= RESP_OKAY;
      end
      else
      begin
         if (s_axi_bvalid_o && s_axi_bready_i)
            s_axi_bvalid_o <= 1'b0;
         if (s_axi_awready_o)
         begin
            s_axi_bvalid_o <= 1'b1;
            s_axi_bresp_o  <= RESP_OKAY;
            case (s_axi_awaddr_i)
               AXI_ADDR_W'(REG_CTRL):    ctrl_q    <= s_axi_wdata_i[3:0];
               AXI_ADDR_W'(REG_SPI_SEL): spi_sel_q <= s_axi_wdata_i[2:0];
               AXI_ADDR_W'(REG_DIVSW):   divsw_q   <= s_axi_wdata_i[1:0];
               AXI_ADDR_W'(REG_LED):     led_q     <= s_axi_wdata_i[6:0];
               AXI_ADDR_W'(REG_STATUS):  ;   // Read only
               default:                  s_axi_bresp_o <= RESP_SLVERR;
            endcase
         end
      end
   end

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         s_axi_rvalid_o <= 1'b0;
         s_axi_rresp_o  <= RESP_OKAY;
         s_axi_rdata_o  <= '0;
      end
      else
      begin
         if (s_axi_rvalid_o && s_axi_rready_i)
            s_axi_rvalid_o <= 1'b0;
         if (s_axi_arready_o)
         begin
            s_axi_rvalid_o <= 1'b1;
            s_axi_rresp_o  <= RESP_OKAY;
            s_axi_rdata_o  <= '0;
            case (s_axi_araddr_i)
               AXI_ADDR_W'(REG_CTRL):    s_axi_rdata_o <= {28'b0, ctrl_q};
               AXI_ADDR_W'(REG_SPI_SEL): s_axi_rdata_o <= {29'b0, spi_sel_q};
               AXI_ADDR_W'(REG_DIVSW):   s_axi_rdata_o <= {30'b0, divsw_q};
               AXI_ADDR_W'(REG_LED):     s_axi_rdata_o <= {25'b0, led_q};
               AXI_ADDR_W'(REG_STATUS):  s_axi_rdata_o <= 32'(tx_uflow_cnt_i);
               default:                  s_axi_rresp_o <= RESP_SLVERR;
            endcase
         end
      end
   end

   assign ctrl_o       = ctrl_q;
   assign lms1_rst_n_o = ctrl_q.lms1_rst_n;
   assign lms2_rst_n_o = ctrl_q.lms2_rst_n;

   // Switches driven as true and complement pairs
   assign divsw1_p_o = divsw_q[1];
   assign divsw1_n_o = ~divsw_q[1];
   assign divsw2_p_o = divsw_q[0];
   assign divsw2_n_o = ~divsw_q[0];
   assign leds_n_o   = ~led_q;   // Drive low to light

   // Enables are active low
   assign sen1_o    = ~spi_sel_q[2];
   assign sen2_o    = ~spi_sel_q[1];
   assign sen_dac_o = ~spi_sel_q[0];

   // Unselected devices see a quiet bus
   assign {sclk1_o, mosi1_o}       = ~sen1_o    ? {spi_sclk_i, spi_mosi_i} : 2'b00;
   assign {sclk2_o, mosi2_o}       = ~sen2_o    ? {spi_sclk_i, spi_mosi_i} : 2'b00;
   assign {sclk_dac_o, mosi_dac_o} = ~sen_dac_o ? {spi_sclk_i, spi_mosi_i} : 2'b00;

   assign spi_miso_o = (~sen1_o & miso1_i) | (~sen2_o & miso2_i);

   // Write response held until the master takes it
   a_bvalid_hold: assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);

endmodule

// ==== rtl/lms_frontend_top.sv ====
// LMS transceiver front end
`timescale 1ns/1ns

module lms_frontend_top
   import lms_pkg::*;
#(
   parameter int AXI_ADDR_W  = 8,
   parameter int UFLOW_CNT_W = 16
)
(
   input  logic                  lms_clk,
   input  logic                  rst_n_i,
   // AXI4-Lite slave
   input  logic [AXI_ADDR_W-1:0] s_axi_awaddr_i,
   input  logic                  s_axi_awvalid_i,
   output logic                  s_axi_awready_o,
   input  logic [31:0]           s_axi_wdata_i,
   input  logic                  s_axi_wvalid_i,
   output logic                  s_axi_wready_o,
   output logic [1:0]            s_axi_bresp_o,
   output logic                  s_axi_bvalid_o,
   input  logic                  s_axi_bready_i,
   input  logic [AXI_ADDR_W-1:0] s_axi_araddr_i,
   input  logic                  s_axi_arvalid_i,
   output logic                  s_axi_arready_o,
   output logic [31:0]           s_axi_rdata_o,
   output logic [1:0]            s_axi_rresp_o,
   output logic                  s_axi_rvalid_o,
   input  logic                  s_axi_rready_i,
   // ADC ports
   input  logic                  rx1_iqsel_i,
   input  dac_word_t             rx1_d_i,
   input  logic                  rx2_iqsel_i,
   input  dac_word_t             rx2_d_i,
   output rx_iq_pair_t           rx_iq_o,
   output logic                  rx1_valid_o,
   output logic                  rx2_valid_o,
   // DAC ports
   input  tx_iq_pair_t           tx_iq_i,
   input  logic                  tx_valid_i,
   output logic                  tx_ready_o,
   output logic                  tx1_en_o,
   output logic                  tx1_iqsel_o,
   output dac_word_t             tx1_d_o,
   output logic                  tx2_en_o,
   output logic                  tx2_iqsel_o,
   output dac_word_t             tx2_d_o,
   // LMS resets, diversity switches, LEDs
   output logic                  lms1_rst_n_o,
   output logic                  lms2_rst_n_o,
   output logic                  divsw1_p_o,
   output logic                  divsw1_n_o,
   output logic                  divsw2_p_o,
   output logic                  divsw2_n_o,
   output logic [6:0]            leds_n_o,
   // SPI
   input  logic                  spi_sclk_i,
   input  logic                  spi_mosi_i,
   output logic                  spi_miso_o,
   output logic                  sen1_o,
   output logic                  sclk1_o,
   output logic                  mosi1_o,
   input  logic                  miso1_i,
   output logic                  sen2_o,
   output logic                  sclk2_o,
   output logic                  mosi2_o,
   input  logic                  miso2_i,
   output logic                  sen_dac_o,
   output logic                  sclk_dac_o,
   output logic                  mosi_dac_o
);

   ctrl_t                  ctrl;
   logic [UFLOW_CNT_W-1:0] tx_uflow_cnt;

   lms_rx_capture u_rx (
      .lms_clk     (lms_clk),
      .rst_n_i     (rst_n_i),
      .ctrl_i      (ctrl),
      .rx1_iqsel_i (rx1_iqsel_i),
      .rx1_d_i     (rx1_d_i),
      .rx2_iqsel_i (rx2_iqsel_i),
      .rx2_d_i     (rx2_d_i),
      .rx_iq_o     (rx_iq_o),
      .rx1_valid_o (rx1_valid_o),
      .rx2_valid_o (rx2_valid_o)
   );

   lms_tx_interleave #(
      .UFLOW_CNT_W (UFLOW_CNT_W)
   ) u_tx (
      .lms_clk        (lms_clk),
      .rst_n_i        (rst_n_i),
      .ctrl_i         (ctrl),
      .tx_iq_i        (tx_iq_i),
      .tx_valid_i     (tx_valid_i),
      .tx_ready_o     (tx_ready_o),
      .tx1_en_o       (tx1_en_o),
      .tx1_iqsel_o    (tx1_iqsel_o),
      .tx1_d_o        (tx1_d_o),
      .tx2_en_o       (tx2_en_o),
      .tx2_iqsel_o    (tx2_iqsel_o),
      .tx2_d_o        (tx2_d_o),
      .tx_uflow_cnt_o (tx_uflow_cnt)
   );

   lms_ctrl #(
      .AXI_ADDR_W  (AXI_ADDR_W),
      .UFLOW_CNT_W (UFLOW_CNT_W)
   ) u_ctrl (
      .lms_clk         (lms_clk),
      .rst_n_i         (rst_n_i),
      .s_axi_awaddr_i  (s_axi_awaddr_i),
      .s_axi_awvalid_i (s_axi_awvalid_i),
      .s_axi_awready_o (s_axi_awready_o),
      .s_axi_wdata_i   (s_axi_wdata_i),
      .s_axi_wvalid_i  (s_axi_wvalid_i),
      .s_axi_wready_o  (s_axi_wready_o),
      .s_axi_bresp_o   (s_axi_bresp_o),
      .s_axi_bvalid_o  (s_axi_bvalid_o),
      .s_axi_bready_i  (s_axi_bready_i),
      .s_axi_araddr_i  (s_axi_araddr_i),
      .s_axi_arvalid_i (s_axi_arvalid_i),
      .s_axi_arready_o (s_axi_arready_o),
      .s_axi_rdata_o   (s_axi_rdata_o),
      .s_axi_rresp_o   (s_axi_rresp_o),
      .s_axi_rvalid_o  (s_axi_rvalid_o),
      .s_axi_rready_i  (s_axi_rready_i),
      .ctrl_o          (ctrl),
      .tx_uflow_cnt_i  (tx_uflow_cnt),
      .lms1_rst_n_o    (lms1_rst_n_o),
      .lms2_rst_n_o    (lms2_rst_n_o),
      .divsw1_p_o      (divsw1_p_o),
      .divsw1_n_o      (divsw1_n_o),
      .divsw2_p_o      (divsw2_p_o),
      .divsw2_n_o      (divsw2_n_o),
      .leds_n_o        (leds_n_o),
      .spi_sclk_i      (spi_sclk_i),
      .spi_mosi_i      (spi_mosi_i),
      .spi_miso_o      (spi_miso_o),
      .sen1_o          (sen1_o),
      .sclk1_o         (sclk1_o),
      .mosi1_o         (mosi1_o),
      .miso1_i         (miso1_i),
      .sen2_o          (sen2_o),
      .sclk2_o         (sclk2_o),
      .mosi2_o         (mosi2_o),
      .miso2_i         (miso2_i),
      .sen_dac_o       (sen_dac_o),
      .sclk_dac_o      (sclk_dac_o),
      .mosi_dac_o      (mosi_dac_o)
   );

endmodule

// ==== tb/tb_lms_frontend.sv ====
// LMS front end testbench
`timescale 1ns/1ns

module tb_lms_frontend
   import lms_pkg::*;
();

   // The tests take about 950 cycles
   localparam int MAX_CYCLES = 3000;

   logic        lms_clk;
   logic        rst_n_i;
   logic [7:0]  s_axi_awaddr_i;
   logic        s_axi_awvalid_i;
   logic        s_axi_awready_o;
   logic [31:0] s_axi_wdata_i;
   logic        s_axi_wvalid_i;
   logic        s_axi_wready_o;
   logic [1:0]  s_axi_bresp_o;
   logic        s_axi_bvalid_o;
   logic        s_axi_bready_i;
   logic [7:0]  s_axi_araddr_i;
   logic        s_axi_arvalid_i;
   logic        s_axi_arready_o;
   logic [31:0] s_axi_rdata_o;
   logic [1:0]  s_axi_rresp_o;
   logic        s_axi_rvalid_o;
   logic        s_axi_rready_i;
   logic        rx1_iqsel_i;
   dac_word_t   rx1_d_i;
   logic        rx2_iqsel_i;
   dac_word_t   rx2_d_i;
   rx_iq_pair_t rx_iq_o;
   logic        rx1_valid_o;
   logic        rx2_valid_o;
   tx_iq_pair_t tx_iq_i;
   logic        tx_valid_i;
   logic        tx_ready_o;
   logic        tx1_en_o;
   logic        tx1_iqsel_o;
   dac_word_t   tx1_d_o;
   logic        tx2_en_o;
   logic        tx2_iqsel_o;
   dac_word_t   tx2_d_o;
   logic        lms1_rst_n_o;
   logic        lms2_rst_n_o;
   logic        divsw1_p_o;
   logic        divsw1_n_o;
   logic        divsw2_p_o;
   logic        divsw2_n_o;
   logic [6:0]  leds_n_o;
   logic        spi_sclk_i;
   logic        spi_mosi_i;
   logic        spi_miso_o;
   logic        sen1_o;
   logic        sclk1_o;
   logic        mosi1_o;
   logic        miso1_i;
   logic        sen2_o;
   logic        sclk2_o;
   logic        mosi2_o;
   logic        miso2_i;
   logic        sen_dac_o;
   logic        sclk_dac_o;
   logic        mosi_dac_o;

   int          seed = 32'he3b9_e3cc;
   int          cycle_cnt = 0;
   logic [31:0] r;
   logic [31:0] r2;
   logic [31:0] rdata;
   logic [1:0]  resp;

   ctrl_t       ctrl_exp = '0;   // Register shadows
   logic [2:0]  sel_exp = '0;
   logic [1:0]  divsw_exp = '0;
   logic [6:0]  led_exp = '0;

   dac_word_t   last_i [2];      // RX pairing model
   logic [1:0]  have_i = '0;
   rx_iq_t      exp_rx1 [$];
   rx_iq_t      exp_rx2 [$];

   logic        m_q_slot = 1'b1; // TX slot model
   dac_word_t   m_d1 = '0;
   dac_word_t   m_d2 = '0;
   dac_word_t   m_h1 = '0;
   dac_word_t   m_h2 = '0;
   logic [15:0] uflow_exp = '0;

   lms_frontend_top dut0 (.*);

   initial
   begin
      lms_clk = 1'b0;
      forever #50 lms_clk = ~lms_clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   always @(posedge lms_clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
         abort_run($sformatf("Timeout, run still busy after %0d cycles", cycle_cnt));
   end

   // Captured sample is the pin word with two zero bits below it
   function automatic rx_iq_t rx_pair(dac_word_t i_w, dac_word_t q_w);
      rx_iq_t p;
      p.i = {i_w, 2'b00};
      p.q = {q_w, 2'b00};
      return p;
   endfunction

   function automatic logic [15:0] pin_state(ctrl_t c, logic [1:0] dsw, logic [6:0] led);
      return {3'b0, c.lms1_rst_n, c.lms2_rst_n, dsw[1], ~dsw[1], dsw[0], ~dsw[0], ~led};
   endfunction

   // Select bits are LMS1, LMS2, DAC from the top
   function automatic logic [15:0] spi_state(logic [2:0] sel, logic sclk, logic mosi,
                                             logic miso1, logic miso2);
      return {6'b0,
              ~sel[2], sel[2] & sclk, sel[2] & mosi,
              ~sel[1], sel[1] & sclk, sel[1] & mosi,
              ~sel[0], sel[0] & sclk, sel[0] & mosi,
              (sel[2] & miso1) | (sel[1] & miso2)};
   endfunction

   task automatic cmp_rx(input string name, input rx_iq_t exp, input rx_iq_t act);
      if (exp !== act)
         abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic cmp_dac(input string name, input dac_word_t exp, input dac_word_t act);
      if (exp !== act)
         abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic cmp_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
         abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic cmp_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
      if (exp !== act)
         abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic cmp_pins(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (exp !== act)
         abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic next_cycle();
      @(posedge lms_clk);
      #10;
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] bresp);
      s_axi_awaddr_i  = addr;
      s_axi_wdata_i   = data;
      s_axi_awvalid_i = 1'b1;
      s_axi_wvalid_i  = 1'b1;
      @(negedge lms_clk);
      while (!s_axi_awready_o && !s_axi_wready_o)
         @(negedge lms_clk);
      if (!(s_axi_awready_o && s_axi_wready_o))
         abort_run("AXI awready and wready were not raised together");
      @(posedge lms_clk);
      case (addr)   // Registers change at this edge
         REG_CTRL:    ctrl_exp  = ctrl_t'(data[3:0]);
         REG_SPI_SEL: sel_exp   = data[2:0];
         REG_DIVSW:   divsw_exp = data[1:0];
         REG_LED:     led_exp   = data[6:0];
         default:     ;
      endcase
      #10;
      s_axi_awvalid_i = 1'b0;
      s_axi_wvalid_i  = 1'b0;
      @(negedge lms_clk);
      while (!s_axi_bvalid_o)
         @(negedge lms_clk);
      bresp = s_axi_bresp_o;
      next_cycle();   // bready is always high
   endtask

   task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] rresp);
      s_axi_araddr_i  = addr;
      s_axi_arvalid_i = 1'b1;
      @(negedge lms_clk);
      while (!s_axi_arready_o)
         @(negedge lms_clk);
      next_cycle();
      s_axi_arvalid_i = 1'b0;
      @(negedge lms_clk);
      while (!s_axi_rvalid_o)
         @(negedge lms_clk);
      data  = s_axi_rdata_o;
      rresp = s_axi_rresp_o;
      next_cycle();
   endtask

   task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
      logic [1:0] bresp;
      axi_write(addr, data, bresp);
      cmp_resp($sformatf("write response at %h", addr), RESP_OKAY, bresp);
   endtask

   task automatic check_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
      logic [31:0] data;
      logic [1:0]  rresp;
      axi_read(addr, data, rresp);
      cmp_resp(name, RESP_OKAY, rresp);
      cmp_reg(name, exp, data);
   endtask

   task automatic check_pins(input string name);
      @(negedge lms_clk);
      cmp_pins(name, pin_state(ctrl_exp, divsw_exp, led_exp),
               {3'b0, lms1_rst_n_o, lms2_rst_n_o, divsw1_p_o, divsw1_n_o,
                divsw2_p_o, divsw2_n_o, leds_n_o});
      cmp_pins({name, " spi"}, spi_state(sel_exp, spi_sclk_i, spi_mosi_i, miso1_i, miso2_i),
               {6'b0, sen1_o, sclk1_o, mosi1_o, sen2_o, sclk2_o, mosi2_o,
                sen_dac_o, sclk_dac_o, mosi_dac_o, spi_miso_o});
      next_cycle();
   endtask

   // Random iqsel gives gaps and repeated I words
   task automatic drive_rx_words(input int n);
      logic [31:0] w;
      repeat (n)
      begin
         w = $random(seed);
         rx1_iqsel_i = w[0];
         rx1_d_i     = w[12:1];
         rx2_iqsel_i = w[13];
         rx2_d_i     = w[25:14];
         next_cycle();
      end
      rx1_iqsel_i = 1'b0;   // Back to idle Q words
      rx2_iqsel_i = 1'b0;
      repeat (6) next_cycle();
   endtask

   // RX pair checker, pins seen here are taken at the next edge
   always @(negedge lms_clk)
   begin
      if (rst_n_i)
      begin
         if (rx1_valid_o)
         begin
            if (exp_rx1.size() == 0)
               abort_run("RX channel 1 raised valid with no pair expected");
            else
               cmp_rx("rx1 pair", exp_rx1.pop_front(), rx_iq_o.ch1);
         end
         if (rx2_valid_o)
         begin
            if (exp_rx2.size() == 0)
               abort_run("RX channel 2 raised valid with no pair expected");
            else
               cmp_rx("rx2 pair", exp_rx2.pop_front(), rx_iq_o.ch2);
         end
         if (ctrl_exp.rx_en && !rx1_iqsel_i && have_i[0])
            exp_rx1.push_back(rx_pair(last_i[0], rx1_d_i));
         if (ctrl_exp.rx_en && !rx2_iqsel_i && have_i[1])
            exp_rx2.push_back(rx_pair(last_i[1], rx2_d_i));
         if (rx1_iqsel_i)
            last_i[0] = rx1_d_i;
         if (rx2_iqsel_i)
            last_i[1] = rx2_d_i;
         have_i = {2{ctrl_exp.rx_en}} & {rx2_iqsel_i, rx1_iqsel_i};
      end
   end

   // TX slot checker
   always @(negedge lms_clk)
   begin
      if (rst_n_i)
      begin
         cmp_pins("tx slot control",
                  {11'b0, ctrl_exp.tx_en, ctrl_exp.tx_en, ctrl_exp.tx_en & m_q_slot,
                   m_q_slot, m_q_slot},
                  {11'b0, tx1_en_o, tx2_en_o, tx_ready_o, tx1_iqsel_o, tx2_iqsel_o});
         cmp_dac("tx1 slot data", m_d1, tx1_d_o);
         cmp_dac("tx2 slot data", m_d2, tx2_d_o);
         if (!ctrl_exp.tx_en)
         begin
            m_q_slot = 1'b1;
            m_d1     = '0;
            m_d2     = '0;
         end
         else if (m_q_slot)
         begin
            if (tx_valid_i)   // Taken at the coming edge
            begin
               m_d1 = tx_iq_i.ch1.i;
               m_d2 = tx_iq_i.ch2.i;
               m_h1 = tx_iq_i.ch1.q;
               m_h2 = tx_iq_i.ch2.q;
            end
            else
            begin
               m_d1 = '0;
               m_d2 = '0;
               m_h1 = '0;
               m_h2 = '0;
               if (uflow_exp != 16'hFFFF)
                  uflow_exp = uflow_exp + 16'd1;
            end
            m_q_slot = 1'b0;
         end
         else
         begin
            m_d1     = m_h1;
            m_d2     = m_h2;
            m_q_slot = 1'b1;
         end
      end
   end

   initial
   begin
      s_axi_awaddr_i  = '0;
      s_axi_awvalid_i = 1'b0;
      s_axi_wdata_i   = '0;
      s_axi_wvalid_i  = 1'b0;
      s_axi_bready_i  = 1'b1;
      s_axi_araddr_i  = '0;
      s_axi_arvalid_i = 1'b0;
      s_axi_rready_i  = 1'b1;
      rx1_iqsel_i     = 1'b0;
      rx1_d_i         = '0;
      rx2_iqsel_i     = 1'b0;
      rx2_d_i         = '0;
      tx_iq_i         = '0;
      tx_valid_i      = 1'b0;
      spi_sclk_i      = 1'b0;
      spi_mosi_i      = 1'b0;
      miso1_i         = 1'b0;
      miso2_i         = 1'b0;
      rst_n_i         = 1'b0;
      repeat (2) @(posedge lms_clk);
      #10;
      rst_n_i = 1'b1;

      // Reset defaults
      check_pins("reset pins");
      check_reg("reset ctrl", REG_CTRL, 32'h0);
      check_reg("reset spi sel", REG_SPI_SEL, 32'h0);
      check_reg("reset divsw", REG_DIVSW, 32'h0);
      check_reg("reset led", REG_LED, 32'h0);
      check_reg("reset status", REG_STATUS, 32'h0);

      // Register readback and pin effects
      for (int k = 0; k < 12; k++)
      begin
         r = $random(seed);
         write_ok(REG_CTRL, r);
         check_reg("ctrl readback", REG_CTRL, {28'b0, r[3:0]});
         r = $random(seed);
         write_ok(REG_LED, r);
         check_reg("led readback", REG_LED, {25'b0, r[6:0]});
         r = $random(seed);
         write_ok(REG_DIVSW, r);
         check_reg("divsw readback", REG_DIVSW, {30'b0, r[1:0]});
         check_pins("register pins");
      end

      // RX capture, LMS out of reset with rx_en set
      write_ok(REG_CTRL, 32'hE);
      drive_rx_words(200);
      if (exp_rx1.size() != 0 || exp_rx2.size() != 0)
         abort_run("RX pairs still missing after the capture run");
      write_ok(REG_CTRL, 32'hC);
      drive_rx_words(40);

      // TX interleave
      write_ok(REG_CTRL, 32'hD);
      repeat (200)
      begin
         r  = $random(seed);
         r2 = $random(seed);
         tx_iq_i    = {r[23:0], r2[23:0]};
         tx_valid_i = (r2[31:30] != 2'b00);
         next_cycle();
      end
      tx_valid_i = 1'b0;
      write_ok(REG_CTRL, 32'hC);
      repeat (3) next_cycle();
      check_reg("underflow count", REG_STATUS, {16'b0, uflow_exp});

      // SPI routing for every select value
      for (int s = 0; s < 8; s++)
      begin
         write_ok(REG_SPI_SEL, 32'(s));
         for (int c = 0; c < 16; c++)
         begin
            {spi_sclk_i, spi_mosi_i, miso1_i, miso2_i} = c[3:0];
            check_pins("spi routing");
         end
      end

      // Offsets off the map
      write_ok(REG_SPI_SEL, 32'h5);
      r = $random(seed);
      write_ok(REG_LED, r);
      r = $random(seed);
      write_ok(REG_DIVSW, r);
      r = $random(seed);
      axi_write(8'h20, r, resp);
      cmp_resp("unmapped write", RESP_SLVERR, resp);
      axi_read(8'h20, rdata, resp);
      cmp_resp("unmapped read", RESP_SLVERR, resp);
      cmp_reg("unmapped read data", 32'h0, rdata);
      check_reg("ctrl kept", REG_CTRL, {28'b0, ctrl_exp});
      check_reg("spi sel kept", REG_SPI_SEL, {29'b0, sel_exp});
      check_reg("divsw kept", REG_DIVSW, {30'b0, divsw_exp});
      check_reg("led kept", REG_LED, {25'b0, led_exp});
      check_reg("status kept", REG_STATUS, {16'b0, uflow_exp});
      check_pins("unmapped pins");

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// ==== flist.f ====
rtl/lms_pkg.sv
rtl/lms_rx_capture.sv
rtl/lms_tx_interleave.sv
rtl/lms_ctrl.sv
rtl/lms_frontend_top.sv
tb/tb_lms_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the front end with its testbench and run it under Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_lms_frontend \
   -f flist.f

# A $fatal in the testbench gives a failing exit status
./obj_dir/Vtb_lms_frontend
